//--- verilog/video_pkg.sv
package video_pkg;

    // ************************************************************
    // Coordinate sizes of the video streams.
    // ************************************************************

    localparam int X_W = 11;                        // Covers lines up to 2048 pixels.
    localparam int Y_W = 10;                        // Covers frames up to 1024 lines.

    // ************************************************************
    // Pixel colour word.
    // ************************************************************

    typedef logic [23:0] rgb_t;                     // Red in 23:16, green in 15:8, blue in 7:0.

    localparam rgb_t RGB_BLACK = 24'h00_00_00;
    localparam rgb_t RGB_RED   = 24'hff_00_00;
    localparam rgb_t RGB_GREEN = 24'h00_ff_00;
    localparam rgb_t RGB_BLUE  = 24'h00_00_ff;

endpackage : video_pkg

//--- verilog/box_pkg.sv
package box_pkg;

    localparam int BOX_BYTES = 6;                   // One record on the wire.
    localparam int C_DEP     = 2;                   // Colour index width.

    // ************************************************************
    // Box record. The reader fills it byte by byte and the parser
    // reads the same 48 bits back as coordinate fields.
    // ************************************************************

    typedef union packed {
        logic [0:BOX_BYTES-1][7:0] bytes;           // Byte 0 is the first one received.
        struct packed {
            logic [video_pkg::X_W-1:0] start_x;
            logic [video_pkg::Y_W-1:0] start_y;
            logic [video_pkg::X_W-1:0] end_x;
            logic [video_pkg::Y_W-1:0] end_y;
            logic [C_DEP-1:0]          color;
            logic [3:0]                pad;
        } fields;
    } box_rec_u;

    // Index 0 turns the box off, so its entry is never drawn.
    localparam video_pkg::rgb_t PALETTE [0:(1<<C_DEP)-1] = '{
        video_pkg::RGB_BLACK,
        video_pkg::RGB_RED,
        video_pkg::RGB_GREEN,
        video_pkg::RGB_BLUE
    };

endpackage : box_pkg

//--- verilog/udp_reader.sv
`timescale 1ns/1ns

module udp_reader #(
    parameter int N_BOX = 1
) (
    input  logic                           clk       ,
    input  logic                           i_rst_n   ,
    input  logic                           i_rx_valid,
    input  logic [7:0]                     i_rx_data ,
    output logic                           o_filled  ,
    output box_pkg::box_rec_u [N_BOX-1:0]  o_data
);

    localparam int BYTE_W = $clog2(box_pkg::BOX_BYTES);
    localparam int REC_W  = $clog2(N_BOX + 1);

    logic [BYTE_W-1:0]             byte_cnt;
    logic [REC_W-1:0]              rec_cnt;
    logic                          taking;
    logic                          last_taken;
    box_pkg::box_rec_u [N_BOX-1:0] work_buf;

    // Once rec_cnt reaches N_BOX the rest of the burst is dropped.
    assign taking = i_rx_valid && (rec_cnt != REC_W'(N_BOX));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            byte_cnt   <= '0;
            rec_cnt    <= '0;
            last_taken <= 1'b0;
        end else begin
            last_taken <= 1'b0;
            if (!i_rx_valid) begin
                byte_cnt <= '0;                     // A short burst starts over.
                rec_cnt  <= '0;
            end else if (taking) begin
                if (byte_cnt == BYTE_W'(box_pkg::BOX_BYTES - 1)) begin
                    byte_cnt   <= '0;
                    rec_cnt    <= rec_cnt + 1'b1;
                    last_taken <= (rec_cnt == REC_W'(N_BOX - 1));
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (taking) begin
            work_buf[rec_cnt].bytes[byte_cnt] <= i_rx_data;
        end
    end

    // The output buffer only changes on a complete payload.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_filled <= 1'b0;
            o_data   <= '0;                         // Colour index 0 keeps every box off.
        end else begin
            o_filled <= last_taken;
            if (last_taken) begin
                o_data <= work_buf;
            end
        end
    end

endmodule : udp_reader

//--- verilog/udp_parser.sv
`timescale 1ns/1ns

module udp_parser #(
    parameter int N_BOX = 1
) (
    input  box_pkg::box_rec_u [N_BOX-1:0]          i_data    ,
    output logic [N_BOX-1:0][video_pkg::X_W-1:0]   o_start_xs,
    output logic [N_BOX-1:0][video_pkg::Y_W-1:0]   o_start_ys,
    output logic [N_BOX-1:0][video_pkg::X_W-1:0]   o_end_xs  ,
    output logic [N_BOX-1:0][video_pkg::Y_W-1:0]   o_end_ys  ,
    output video_pkg::rgb_t [N_BOX-1:0]            o_colors  ,
    output logic [N_BOX-1:0]                       o_enables
);

    // ************************************************************
    // Field decode, one slice per box.
    // ************************************************************

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        logic color_on;
        logic ordered;

        assign o_start_xs[i] = i_data[i].fields.start_x;
        assign o_start_ys[i] = i_data[i].fields.start_y;
        assign o_end_xs[i]   = i_data[i].fields.end_x;
        assign o_end_ys[i]   = i_data[i].fields.end_y;
        assign o_colors[i]   = box_pkg::PALETTE[i_data[i].fields.color];

        assign color_on = (i_data[i].fields.color != '0);

        // An inverted corner pair would give a box that wraps, so drop it.
        assign ordered = (i_data[i].fields.start_x <= i_data[i].fields.end_x) &&
                         (i_data[i].fields.start_y <= i_data[i].fields.end_y);

        assign o_enables[i] = color_on && ordered;
    end

endmodule : udp_parser

//--- verilog/frame_process.sv
`timescale 1ns/1ns

module frame_process #(
    parameter int N_BOX       = 1,
    parameter int H_BOX_WIDTH = 2,
    parameter int V_BOX_WIDTH = 2
) (
    input  logic                                 clk       ,
    input  logic                                 i_rst_n   ,
    input  logic                                 i_vsync   ,
    input  logic                                 i_hsync   ,
    input  logic                                 i_de      ,
    input  video_pkg::rgb_t                      i_rgb     ,
    input  logic [N_BOX-1:0][video_pkg::X_W-1:0] i_start_xs,
    input  logic [N_BOX-1:0][video_pkg::Y_W-1:0] i_start_ys,
    input  logic [N_BOX-1:0][video_pkg::X_W-1:0] i_end_xs  ,
    input  logic [N_BOX-1:0][video_pkg::Y_W-1:0] i_end_ys  ,
    input  video_pkg::rgb_t [N_BOX-1:0]          i_colors  ,
    input  logic [N_BOX-1:0]                     i_enables ,
    output logic                                 o_vsync   ,
    output logic                                 o_hsync   ,
    output logic                                 o_de      ,
    output video_pkg::rgb_t                      o_rgb
);

    localparam int XW = video_pkg::X_W;
    localparam int YW = video_pkg::Y_W;

    logic                      vsync_d;
    logic                      de_d;
    logic                      vsync_rise;
    logic                      de_fall;
    logic [XW-1:0]             x_cnt;
    logic [YW-1:0]             y_cnt;
    logic [N_BOX-1:0][XW-1:0]  sh_start_xs;
    logic [N_BOX-1:0][YW-1:0]  sh_start_ys;
    logic [N_BOX-1:0][XW-1:0]  sh_end_xs;
    logic [N_BOX-1:0][YW-1:0]  sh_end_ys;
    video_pkg::rgb_t [N_BOX-1:0] sh_colors;
    logic [N_BOX-1:0]          sh_enables;
    logic [N_BOX-1:0]          hit;
    video_pkg::rgb_t           pix_rgb;

    assign vsync_rise = i_vsync & ~vsync_d;
    assign de_fall    = ~i_de & de_d;

    // ************************************************************
    // Pixel position of the incoming stream.
    // ************************************************************

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            vsync_d <= i_vsync;
            de_d    <= i_de;
            if (de_fall) begin
                x_cnt <= '0;
            end else if (i_de) begin
                x_cnt <= x_cnt + 1'b1;
            end
            if (vsync_rise) begin
                y_cnt <= '0;
            end else if (de_fall) begin
                y_cnt <= y_cnt + 1'b1;              // One line done.
            end
        end
    end

    // Boxes only change between frames so a frame is never drawn half old, half new.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sh_enables <= '0;
        end else if (vsync_rise) begin
            sh_enables <= i_enables;
        end
    end

    always_ff @(posedge clk) begin
        if (vsync_rise) begin
            sh_start_xs <= i_start_xs;
            sh_start_ys <= i_start_ys;
            sh_end_xs   <= i_end_xs;
            sh_end_ys   <= i_end_ys;
            sh_colors   <= i_colors;
        end
    end

    // ************************************************************
    // Border test per box, then the lowest box number wins.
    // ************************************************************

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        logic in_x;
        logic in_y;
        logic edge_x;
        logic edge_y;

        assign in_x   = (x_cnt >= sh_start_xs[i]) && (x_cnt <= sh_end_xs[i]);
        assign in_y   = (y_cnt >= sh_start_ys[i]) && (y_cnt <= sh_end_ys[i]);
        assign edge_x = ((x_cnt - sh_start_xs[i]) < XW'(H_BOX_WIDTH)) ||
                        ((sh_end_xs[i] - x_cnt) < XW'(H_BOX_WIDTH));
        assign edge_y = ((y_cnt - sh_start_ys[i]) < YW'(V_BOX_WIDTH)) ||
                        ((sh_end_ys[i] - y_cnt) < YW'(V_BOX_WIDTH));
        assign hit[i] = i_de && sh_enables[i] && in_x && in_y && (edge_x || edge_y);
    end

    always_comb begin
        pix_rgb = i_rgb;
        for (int i = N_BOX - 1; i >= 0; i--) begin
            if (hit[i]) begin
                pix_rgb = sh_colors[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_vsync <= 1'b0;
            o_hsync <= 1'b0;
            o_de    <= 1'b0;
            o_rgb   <= '0;
        end else begin
            o_vsync <= i_vsync;
            o_hsync <= i_hsync;
            o_de    <= i_de;
            o_rgb   <= pix_rgb;
        end
    end

endmodule : frame_process

//--- verilog/pack_switch.sv
`timescale 1ns/1ns

module pack_switch (
    input  logic            clk      ,
    input  logic            i_rst_n  ,
    input  logic            i_key    ,
    input  logic            i_vsync_1,
    input  logic            i_hsync_1,
    input  logic            i_de_1   ,
    input  video_pkg::rgb_t i_rgb_1  ,
    input  logic            i_vsync_2,
    input  logic            i_hsync_2,
    input  logic            i_de_2   ,
    input  video_pkg::rgb_t i_rgb_2  ,
    output logic            o_vsync  ,
    output logic            o_hsync  ,
    output logic            o_de     ,
    output video_pkg::rgb_t o_rgb
);

    logic key_d;
    logic sel;                                      // Low picks camera 1.

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            key_d <= 1'b0;
            sel   <= 1'b0;
        end else begin
            key_d <= i_key;
            if (i_key && !key_d) begin
                sel <= ~sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_vsync <= 1'b0;
            o_hsync <= 1'b0;
            o_de    <= 1'b0;
            o_rgb   <= '0;
        end else begin
            o_vsync <= sel ? i_vsync_2 : i_vsync_1;
            o_hsync <= sel ? i_hsync_2 : i_hsync_1;
            o_de    <= sel ? i_de_2    : i_de_1;
            o_rgb   <= sel ? i_rgb_2   : i_rgb_1;
        end
    end

endmodule : pack_switch

//--- verilog/aim_bot_core.sv
`timescale 1ns/1ns

module aim_bot_core #(
    parameter int N_BOX       = 1,
    parameter int H_BOX_WIDTH = 2,
    parameter int V_BOX_WIDTH = 2
) (
    input  logic            clk         ,
    input  logic            i_rst_n     ,
    input  logic            i_cam_key   ,
    input  logic            i_cam1_vsync,
    input  logic            i_cam1_hsync,
    input  logic            i_cam1_de   ,
    input  video_pkg::rgb_t i_cam1_rgb  ,
    input  logic            i_cam2_vsync,
    input  logic            i_cam2_hsync,
    input  logic            i_cam2_de   ,
    input  video_pkg::rgb_t i_cam2_rgb  ,
    input  logic            i_rx_valid  ,
    input  logic [7:0]      i_rx_data   ,
    output logic            o_vsync     ,
    output logic            o_hsync     ,
    output logic            o_de        ,
    output video_pkg::rgb_t o_rgb       ,
    output logic            o_udp_filled
);

    // ************************************************************
    // Box records from the UDP payload.
    // ************************************************************

    box_pkg::box_rec_u [N_BOX-1:0]          udp_data;
    logic [N_BOX-1:0][video_pkg::X_W-1:0]   dw_start_xs;
    logic [N_BOX-1:0][video_pkg::Y_W-1:0]   dw_start_ys;
    logic [N_BOX-1:0][video_pkg::X_W-1:0]   dw_end_xs;
    logic [N_BOX-1:0][video_pkg::Y_W-1:0]   dw_end_ys;
    video_pkg::rgb_t [N_BOX-1:0]            dw_colors;
    logic [N_BOX-1:0]                       dw_enables;

    udp_reader #(.N_BOX(N_BOX)) u_udp_reader (
        .clk       (clk         ),
        .i_rst_n   (i_rst_n     ),
        .i_rx_valid(i_rx_valid  ),
        .i_rx_data (i_rx_data   ),
        .o_filled  (o_udp_filled),
        .o_data    (udp_data    )
    );

    udp_parser #(.N_BOX(N_BOX)) u_udp_parser (
        .i_data    (udp_data   ),
        .o_start_xs(dw_start_xs),
        .o_start_ys(dw_start_ys),
        .o_end_xs  (dw_end_xs  ),
        .o_end_ys  (dw_end_ys  ),
        .o_colors  (dw_colors  ),
        .o_enables (dw_enables )
    );

    // ************************************************************
    // Overlay on both cameras, then pick one for the display.
    // ************************************************************

    logic            cam1_vsync, cam1_hsync, cam1_de;
    video_pkg::rgb_t cam1_rgb;
    logic            cam2_vsync, cam2_hsync, cam2_de;
    video_pkg::rgb_t cam2_rgb;

    frame_process #(
        .N_BOX      (N_BOX      ),
        .H_BOX_WIDTH(H_BOX_WIDTH),
        .V_BOX_WIDTH(V_BOX_WIDTH)
    ) u_cam1_process (
        .clk       (clk         ),
        .i_rst_n   (i_rst_n     ),
        .i_vsync   (i_cam1_vsync),
        .i_hsync   (i_cam1_hsync),
        .i_de      (i_cam1_de   ),
        .i_rgb     (i_cam1_rgb  ),
        .i_start_xs(dw_start_xs ),
        .i_start_ys(dw_start_ys ),
        .i_end_xs  (dw_end_xs   ),
        .i_end_ys  (dw_end_ys   ),
        .i_colors  (dw_colors   ),
        .i_enables (dw_enables  ),
        .o_vsync   (cam1_vsync  ),
        .o_hsync   (cam1_hsync  ),
        .o_de      (cam1_de     ),
        .o_rgb     (cam1_rgb    )
    );

    frame_process #(
        .N_BOX      (N_BOX      ),
        .H_BOX_WIDTH(H_BOX_WIDTH),
        .V_BOX_WIDTH(V_BOX_WIDTH)
    ) u_cam2_process (
        .clk       (clk         ),
        .i_rst_n   (i_rst_n     ),
        .i_vsync   (i_cam2_vsync),
        .i_hsync   (i_cam2_hsync),
        .i_de      (i_cam2_de   ),
        .i_rgb     (i_cam2_rgb  ),
        .i_start_xs(dw_start_xs ),
        .i_start_ys(dw_start_ys ),
        .i_end_xs  (dw_end_xs   ),
        .i_end_ys  (dw_end_ys   ),
        .i_colors  (dw_colors   ),
        .i_enables (dw_enables  ),
        .o_vsync   (cam2_vsync  ),
        .o_hsync   (cam2_hsync  ),
        .o_de      (cam2_de     ),
        .o_rgb     (cam2_rgb    )
    );

    pack_switch u_switch_cam (
        .clk      (clk       ),
        .i_rst_n  (i_rst_n   ),
        .i_key    (i_cam_key ),
        .i_vsync_1(cam1_vsync),
        .i_hsync_1(cam1_hsync),
        .i_de_1   (cam1_de   ),
        .i_rgb_1  (cam1_rgb  ),
        .i_vsync_2(cam2_vsync),
        .i_hsync_2(cam2_hsync),
        .i_de_2   (cam2_de   ),
        .i_rgb_2  (cam2_rgb  ),
        .o_vsync  (o_vsync   ),
        .o_hsync  (o_hsync   ),
        .o_de     (o_de      ),
        .o_rgb    (o_rgb     )
    );

endmodule : aim_bot_core

//--- bench/aim_bot_core_checker.sv
`timescale 1ns/1ns

module aim_bot_core_checker (
    input  logic            clk         ,
    input  logic            i_rst_n     ,
    input  logic            i_cam_key   ,
    input  logic            i_cam1_vsync,
    input  logic            i_cam2_vsync,
    input  logic            i_vsync     ,
    input  logic            i_hsync     ,
    input  logic            i_de        ,
    input  video_pkg::rgb_t i_rgb       ,
    input  logic            i_udp_filled
);

    int unsigned fail_cnt = 0;
    logic        key_d;
    logic        cam2_sel;

    // Key edge toggles the camera, as on the display switch.
    always @(posedge clk) begin
        if (!i_rst_n) begin
            key_d    <= 1'b0;
            cam2_sel <= 1'b0;
        end else begin
            key_d <= i_cam_key;
            if (i_cam_key && !key_d) begin
                cam2_sel <= ~cam2_sel;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !i_rst_n |=> (!i_vsync && !i_hsync && !i_de && i_rgb == '0 && !i_udp_filled))
    else begin
        fail_cnt++;
        $error("Outputs not low after a reset cycle.");
    end

    a_filled_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_udp_filled |=> !i_udp_filled)
    else begin
        fail_cnt++;
        $error("o_udp_filled high for two cycles.");
    end

    // Two register stages from camera input to the display port.
    a_vsync_path: assert property (@(posedge clk)
        ($past(i_rst_n) && $past(i_rst_n, 2)) |->
        i_vsync == ($past(cam2_sel) ? $past(i_cam2_vsync, 2) : $past(i_cam1_vsync, 2)))
    else begin
        fail_cnt++;
        $error("o_vsync does not follow the selected camera.");
    end

endmodule : aim_bot_core_checker

bind aim_bot_core aim_bot_core_checker u_checker (
    .clk         (clk         ),
    .i_rst_n     (i_rst_n     ),
    .i_cam_key   (i_cam_key   ),
    .i_cam1_vsync(i_cam1_vsync),
    .i_cam2_vsync(i_cam2_vsync),
    .i_vsync     (o_vsync     ),
    .i_hsync     (o_hsync     ),
    .i_de        (o_de        ),
    .i_rgb       (o_rgb       ),
    .i_udp_filled(o_udp_filled)
);

//--- bench/aim_bot_core_tb.sv
`timescale 1ns/1ns

module aim_bot_core_tb;

    localparam int N_BOX      = 2;
    localparam int BORDER     = 2;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 8;
    localparam int H_ACT      = 32;
    localparam int V_ACT      = 12;
    localparam int LINE_CYC   = 2 + 2 + H_ACT + 2;        // Sync, back porch, active, front porch.
    localparam int FRAME_CYC  = 2 + 2 + V_ACT * LINE_CYC + 4;
    localparam int N_FRAMES   = 11;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            cam_key;
    logic            cam1_vsync, cam1_hsync, cam1_de;
    logic            cam2_vsync, cam2_hsync, cam2_de;
    video_pkg::rgb_t cam1_rgb, cam2_rgb;
    logic            rx_valid;
    logic [7:0]      rx_data;
    logic            vsync, hsync, de;
    video_pkg::rgb_t rgb;
    logic            udp_filled;

    int              seed = 32'h2fe91b9a;
    int              errors = 0;
    int              tests_run = 0;
    int              tests_ok = 0;
    int              filled_cnt = 0;
    int              painted_cnt = 0;

    // Reference model state.
    logic [47:0]     pub_rec [N_BOX];
    logic [47:0]     sh_rec [N_BOX];
    logic            st1_de [2];
    logic            st1_hs [2];
    video_pkg::rgb_t st1_rgb [2];
    logic            st2_de = 1'b0;
    logic            st2_hs = 1'b0;
    video_pkg::rgb_t st2_rgb = '0;
    int              x_m, y_m;
    logic            vs_m, de_m, key_m, sel_m;

    aim_bot_core #(
        .N_BOX      (N_BOX ),
        .H_BOX_WIDTH(BORDER),
        .V_BOX_WIDTH(BORDER)
    ) aim_bot_core_i (
        .clk         (clk       ),
        .i_rst_n     (rst_n     ),
        .i_cam_key   (cam_key   ),
        .i_cam1_vsync(cam1_vsync),
        .i_cam1_hsync(cam1_hsync),
        .i_cam1_de   (cam1_de   ),
        .i_cam1_rgb  (cam1_rgb  ),
        .i_cam2_vsync(cam2_vsync),
        .i_cam2_hsync(cam2_hsync),
        .i_cam2_de   (cam2_de   ),
        .i_cam2_rgb  (cam2_rgb  ),
        .i_rx_valid  (rx_valid  ),
        .i_rx_data   (rx_data   ),
        .o_vsync     (vsync     ),
        .o_hsync     (hsync     ),
        .o_de        (de        ),
        .o_rgb       (rgb       ),
        .o_udp_filled(udp_filled)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_FRAMES * FRAME_CYC + 2000) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished.");
        $display(">>> FAIL");
        $finish;
    end

    // ************************************************************
    // Reference model.
    // ************************************************************

    function automatic logic [47:0] box_record(input int sx, input int sy, input int ex,
                                               input int ey, input int c);
        return {sx[10:0], sy[9:0], ex[10:0], ey[9:0], c[1:0], 4'h0};
    endfunction

    function automatic video_pkg::rgb_t palette_rgb(input logic [1:0] c);
        case (c)
            2'd1:    return 24'hff0000;
            2'd2:    return 24'h00ff00;
            2'd3:    return 24'h0000ff;
            default: return 24'h000000;
        endcase
    endfunction

    // The first box that claims the pixel gives its colour.
    function automatic video_pkg::rgb_t paint_pixel(input int x, input int y,
                                                    input video_pkg::rgb_t pix);
        int         sx, sy, ex, ey;
        logic [1:0] c;
        for (int i = 0; i < N_BOX; i++) begin
            sx = sh_rec[i][47:37];
            sy = sh_rec[i][36:27];
            ex = sh_rec[i][26:16];
            ey = sh_rec[i][15:6];
            c  = sh_rec[i][5:4];
            if (c != 0 && sx <= ex && sy <= ey && x >= sx && x <= ex && y >= sy && y <= ey &&
                (x - sx < BORDER || ex - x < BORDER || y - sy < BORDER || ey - y < BORDER)) begin
                return palette_rgb(c);
            end
        end
        return pix;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    always @(negedge clk) begin
        if (de !== st2_de) begin
            flag_mismatch("o_de", st2_de, de);
        end
        if (hsync !== st2_hs) begin
            flag_mismatch("o_hsync", st2_hs, hsync);
        end
        if (rgb !== st2_rgb) begin
            flag_mismatch("o_rgb", st2_rgb, rgb);
        end
        if (udp_filled === 1'b1) begin
            filled_cnt++;
        end
        // Camera 1 never carries a pure palette colour, so such a pixel is a drawn border.
        if (de === 1'b1 &&
            (rgb === 24'hff0000 || rgb === 24'h00ff00 || rgb === 24'h0000ff)) begin
            painted_cnt++;
        end
        st2_de  = sel_m ? st1_de[1] : st1_de[0];         // Switch stage.
        st2_hs  = sel_m ? st1_hs[1] : st1_hs[0];
        st2_rgb = sel_m ? st1_rgb[1] : st1_rgb[0];
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                st1_de[i]  = 1'b0;
                st1_hs[i]  = 1'b0;
                st1_rgb[i] = '0;
                sh_rec[i]  = '0;
            end
            st2_de  = 1'b0;
            st2_hs  = 1'b0;
            st2_rgb = '0;
            x_m     = 0;
            y_m     = 0;
            {vs_m, de_m, key_m, sel_m} = '0;
        end else begin
            if (cam1_vsync && !vs_m) begin
                sh_rec = pub_rec;                        // Boxes latch at frame start.
            end
            st1_de[0]  = cam1_de;
            st1_de[1]  = cam2_de;
            st1_hs[0]  = cam1_hsync;
            st1_hs[1]  = cam2_hsync;
            st1_rgb[0] = cam1_de ? paint_pixel(x_m, y_m, cam1_rgb) : cam1_rgb;
            st1_rgb[1] = cam2_de ? paint_pixel(x_m, y_m, cam2_rgb) : cam2_rgb;
            if (!cam1_de && de_m) begin
                x_m = 0;
            end else if (cam1_de) begin
                x_m++;
            end
            if (cam1_vsync && !vs_m) begin
                y_m = 0;
            end else if (!cam1_de && de_m) begin
                y_m++;
            end
            vs_m = cam1_vsync;
            de_m = cam1_de;
            if (cam_key && !key_m) begin
                sel_m = !sel_m;
            end
            key_m = cam_key;
        end
    end

    // ************************************************************
    // Stimulus.
    // ************************************************************

    task automatic drive_cycle(input logic vs, input logic hs, input logic act,
                               input int x, input int y);
        int rnd;
        rnd = $random(seed);
        @(posedge clk);
        cam1_vsync <= vs;
        cam1_hsync <= hs;
        cam1_de    <= act;
        cam1_rgb   <= act ? {x[7:0], y[7:0], 8'h3c} : '0;
        cam2_vsync <= vs;
        cam2_hsync <= hs;
        cam2_de    <= act;
        cam2_rgb   <= act ? rnd[23:0] : '0;
    endtask

    task automatic play_frame();
        repeat (2) drive_cycle(1'b1, 1'b0, 1'b0, 0, 0);
        repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, 0, 0);
        for (int y = 0; y < V_ACT; y++) begin
            repeat (2) drive_cycle(1'b0, 1'b1, 1'b0, 0, 0);
            repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, 0, 0);
            for (int x = 0; x < H_ACT; x++) begin
                drive_cycle(1'b0, 1'b0, 1'b1, x, y);
            end
            repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, 0, 0);
        end
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 0, 0);
    endtask

    // Records go out first to last, most significant byte first.
    task automatic send_burst(input logic [95:0] payload, input int n_bytes);
        for (int i = 0; i < n_bytes; i++) begin
            @(posedge clk);
            rx_valid <= 1'b1;
            rx_data  <= (i < 12) ? payload[95 - 8 * i -: 8] : 8'(i * 17);
        end
        @(posedge clk);
        rx_valid <= 1'b0;
        repeat (2) @(posedge clk);
        if (n_bytes >= 12) begin
            pub_rec[0] = payload[95:48];
            pub_rec[1] = payload[47:0];
        end
    endtask

    task automatic press_key();
        @(posedge clk);
        cam_key <= 1'b1;
        repeat (3) @(posedge clk);
        cam_key <= 1'b0;
    endtask

    task automatic expect_pulses(input int filled_start, input int n);
        if (filled_cnt - filled_start != n) begin
            flag_mismatch("o_udp_filled pulses", n, filled_cnt - filled_start);
        end
    endtask

    task automatic close_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            tests_ok++;
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    // ************************************************************
    // Directed tests.
    // ************************************************************

    task automatic expect_outputs_low();
        if (de !== 1'b0) begin
            flag_mismatch("o_de", 0, de);
        end
        if (vsync !== 1'b0) begin
            flag_mismatch("o_vsync", 0, vsync);
        end
        if (udp_filled !== 1'b0) begin
            flag_mismatch("o_udp_filled", 0, udp_filled);
        end
    endtask

    task automatic check_reset_state();
        int err_start;
        err_start = errors;
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            if (i == RST_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            expect_outputs_low();
        end
        repeat (2) begin
            @(negedge clk);
            expect_outputs_low();
        end
        play_frame();                                    // No boxes, so a plain copy.
        close_test("reset state", err_start);
    endtask

    task automatic draw_one_box();
        int err_start;
        int filled_start;
        err_start    = errors;
        filled_start = filled_cnt;
        painted_cnt  = 0;
        fork
            play_frame();
            begin
                repeat (20) @(posedge clk);
                send_burst({box_record(4, 2, 12, 8, 1), box_record(0, 0, 0, 0, 0)}, 12);
            end
        join
        expect_pulses(filled_start, 1);
        if (painted_cnt != 0) begin
            $display("Box pixels showed up in the frame that was running at publication.");
            errors++;
        end
        painted_cnt = 0;
        play_frame();
        if (painted_cnt == 0) begin
            $display("Box 0 did not show up in the frame after publication.");
            errors++;
        end
        close_test("box drawing", err_start);
    endtask

    task automatic priority_and_disable();
        int err_start;
        int filled_start;
        err_start    = errors;
        filled_start = filled_cnt;
        send_burst({box_record(4, 2, 14, 9, 1), box_record(10, 5, 22, 11, 3)}, 12);
        play_frame();
        send_burst({box_record(4, 2, 14, 9, 1), box_record(10, 5, 22, 11, 0)}, 12);
        play_frame();
        send_burst({box_record(4, 2, 14, 9, 1), box_record(22, 1, 16, 6, 2)}, 12);
        play_frame();
        expect_pulses(filled_start, 3);
        close_test("priority and disable", err_start);
    endtask

    task automatic burst_lengths();
        int err_start;
        int filled_start;
        err_start    = errors;
        filled_start = filled_cnt;
        send_burst({box_record(0, 0, 31, 11, 3), box_record(0, 0, 31, 11, 3)}, 7);
        expect_pulses(filled_start, 0);
        play_frame();
        filled_start = filled_cnt;
        send_burst({box_record(2, 1, 9, 10, 2), box_record(16, 3, 29, 8, 3)}, 15);
        expect_pulses(filled_start, 1);
        play_frame();
        close_test("short and long bursts", err_start);
    endtask

    task automatic camera_switch();
        int err_start;
        err_start = errors;
        fork
            play_frame();
            begin
                repeat (FRAME_CYC / 2) @(posedge clk);
                press_key();
            end
        join
        play_frame();                                    // A whole frame from camera 2.
        fork
            play_frame();
            begin
                repeat (FRAME_CYC / 3) @(posedge clk);
                press_key();
            end
        join
        close_test("camera switch", err_start);
    endtask

    initial begin
        rst_n      = 1'b0;
        cam_key    = 1'b0;
        {cam1_vsync, cam1_hsync, cam1_de} = '0;
        {cam2_vsync, cam2_hsync, cam2_de} = '0;
        cam1_rgb   = '0;
        cam2_rgb   = '0;
        rx_valid   = 1'b0;
        rx_data    = '0;
        pub_rec[0] = '0;
        pub_rec[1] = '0;
        check_reset_state();
        draw_one_box();
        priority_and_disable();
        burst_lengths();
        camera_switch();
        repeat (4) @(posedge clk);
        errors = errors + aim_bot_core_i.u_checker.fail_cnt;
        $display("Tests passed: %0d of %0d, errors: %0d", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : aim_bot_core_tb

//--- aim_bot_core.f
verilog/video_pkg.sv
verilog/box_pkg.sv
verilog/udp_reader.sv
verilog/udp_parser.sv
verilog/frame_process.sv
verilog/pack_switch.sv
verilog/aim_bot_core.sv
bench/aim_bot_core_checker.sv
bench/aim_bot_core_tb.sv

//--- Bender.yml
package:
  name: aim_bot_core

sources:
  # Packages first, then the design from the leaves up.
  - verilog/video_pkg.sv
  - verilog/box_pkg.sv
  - verilog/udp_reader.sv
  - verilog/udp_parser.sv
  - verilog/frame_process.sv
  - verilog/pack_switch.sv
  - verilog/aim_bot_core.sv
  - target: test
    files:
      - bench/aim_bot_core_checker.sv
      - bench/aim_bot_core_tb.sv
